// File: src.f
hw/uart_reg_pkg.sv
hw/uart_frame_pkg.sv
hw/uart_core_if.sv
hw/apb_uart_regs.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/apb_uart.sv
tb/tb_apb_uart.sv

// File: Bender.yml
package:
  name: apb_uart

sources:
  - files:
      - hw/uart_reg_pkg.sv
      - hw/uart_frame_pkg.sv
      - hw/uart_core_if.sv
      - hw/apb_uart_regs.sv
      - hw/uart_baud_gen.sv
      - hw/uart_tx.sv
      - hw/uart_rx.sv
      - hw/apb_uart.sv
  - target: test
    files:
      - tb/tb_apb_uart.sv

// File: tb/tb_apb_uart.sv
// default DUT parameters only; all serial traffic runs at rate 7 (921600) on a 125 MHz clk
`default_nettype none

module tb_apb_uart import uart_reg_pkg::*, uart_frame_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SYS_FREQ = 125_000_000;
    localparam int unsigned OVERSAMPLE = 16;
    localparam baud_sel_t RATE_SEL = 3'd7;
    localparam int BIT_CYCLES = (SYS_FREQ / (BAUD_TABLE[RATE_SEL] * OVERSAMPLE)) * OVERSAMPLE;
    // start, 8 data, parity, 2 stop
    localparam int FRAME_CYCLES = 12 * BIT_CYCLES;
    localparam int NUM_FORMATS = 8;
    localparam int BYTES_PER_FORMAT = 2;
    localparam int NUM_FRAMES = NUM_FORMATS * BYTES_PER_FORMAT + 4 + 1 + 2;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES * 2;
    // LCR[4:0] per entry: odd, parity enable, two stop, data bit code
    localparam logic [4:0] FORMATS [NUM_FORMATS] = '{
        5'h00, 5'h09, 5'h1E, 5'h07, 5'h0B, 5'h1F, 5'h1C, 5'h02
    };

    logic       clk;
    logic       preset_n;
    logic       psel, penable, pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata, prdata;
    logic       pready, pslverr, irq, tx_line, rx_line;
    logic       loopback, drv_line;
    logic [31:0] rng;
    int         errors, checks;
    uart_byte_t sb_q [$];

    assign rx_line = loopback ? tx_line : drv_line;

    apb_uart i_apb_uart (
        .clk       (clk),
        .preset_n  (preset_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .irq_o     (irq),
        .rx_i      (rx_line),
        .tx_o      (tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assert property (@(posedge clk) disable iff (!preset_n) pready)
    else begin
        errors++;
        $display("pready_o went low at %0t ns", $time);
    end

    assert property (@(posedge clk) disable iff (!preset_n) pslverr |-> (psel && penable))
    else begin
        errors++;
        $display("pslverr_o raised outside an access phase at %0t ns", $time);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // code n means 5+n data bits
    function automatic uart_byte_t data_mask(input data_bits_t code);
        return uart_byte_t'((1 << (5 + int'(code))) - 1);
    endfunction

    function automatic apb_data_t lcr_word(input logic [4:0] fmt);
        return apb_data_t'({RATE_SEL, fmt});
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic flag_error(input string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    // polls LSR and returns the OR of every value seen
    task automatic wait_lsr(input logic [7:0] mask, output apb_data_t seen);
        apb_data_t lsr;
        logic err;
        int waited;
        seen = '0;
        waited = 0;
        while ((seen[7:0] & mask) == 0 && waited < 2 * FRAME_CYCLES) begin
            apb_read(ADDR_LSR, lsr, err);
            seen = seen | lsr;
            waited += 3;
        end
        if ((seen[7:0] & mask) == 0) begin
            flag_error("LSR status bits never set while waiting for a frame");
        end
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        while (!irq && waited < FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!irq) begin
            flag_error("irq_o did not rise");
        end
    endtask

    task automatic check_rdr();
        apb_data_t data;
        logic err;
        uart_byte_t exp;
        apb_read(ADDR_RDR, data, err);
        if (sb_q.size() == 0) begin
            flag_error("RDR read with no byte expected");
        end else begin
            exp = sb_q.pop_front();
            check_value("RDR", data, {24'b0, exp});
        end
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        drv_line <= b;
        repeat (BIT_CYCLES - 1) @(posedge clk);
    endtask

    task automatic send_serial(input uart_byte_t data, input logic [4:0] fmt,
                               input logic corrupt_parity);
        uart_byte_t masked;
        logic par;
        masked = data & data_mask(fmt[1:0]);
        par = (^masked) ^ fmt[4] ^ corrupt_parity;
        drive_bit(1'b0);
        for (int i = 0; i < 5 + int'(fmt[1:0]); i++) begin
            drive_bit(masked[i]);
        end
        if (fmt[3]) begin
            drive_bit(par);
        end
        drive_bit(1'b1);
        if (fmt[2]) begin
            drive_bit(1'b1);
        end
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        apb_data_t data, seen;
        logic err;
        uart_byte_t b1, b2;
        errors = 0;
        checks = 0;
        rng = 32'd27206;
        preset_n <= 1'b0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        loopback <= 1'b0;
        drv_line <= 1'b1;
        repeat (10) @(posedge clk);
        preset_n <= 1'b1;

        // reset values
        @(negedge clk);
        check_value("irq_o", irq, 0);
        check_value("tx_o", tx_line, 1);
        apb_read(ADDR_LSR, data, err);
        check_value("LSR", data, 32'h10);
        apb_read(ADDR_IIR, data, err);
        check_value("IIR", data, 32'h1);

        // register access and error responses
        apb_write(ADDR_LCR, 32'hA5, err);
        check_value("pslverr_o", err, 0);
        apb_read(ADDR_LCR, data, err);
        check_value("LCR", data, 32'hA5);
        apb_write(ADDR_OCR, 32'h2, err);
        apb_read(ADDR_OCR, data, err);
        check_value("OCR", data, 32'h2);
        apb_write(ADDR_IER, 32'h5, err);
        apb_read(ADDR_IER, data, err);
        check_value("IER", data, 32'h5);
        apb_write(12'h01C, 32'h1, err);
        check_value("pslverr_o", err, 1);
        apb_read(12'h020, data, err);
        check_value("pslverr_o", err, 1);
        apb_write(ADDR_LSR, 32'hFF, err);
        check_value("pslverr_o", err, 1);
        apb_write(ADDR_IER, 32'h0, err);

        // loopback through all formats
        @(posedge clk);
        loopback <= 1'b1;
        apb_write(ADDR_OCR, 32'h3, err);
        for (int f = 0; f < NUM_FORMATS; f++) begin
            apb_write(ADDR_LCR, lcr_word(FORMATS[f]), err);
            for (int b = 0; b < BYTES_PER_FORMAT; b++) begin
                rng = xorshift32(rng);
                sb_q.push_back(rng[7:0] & data_mask(FORMATS[f][1:0]));
                apb_write(ADDR_TDR, {24'b0, rng[7:0]}, err);
                check_value("pslverr_o", err, 0);
                wait_lsr(8'h01, seen);
                check_value("LSR.DATA_READY", seen[LSR_DATA_READY], 1);
                check_value("LSR error bits", seen & 32'h4C, 0);
                check_rdr();
            end
        end

        // transmit FIFO fills while the transmitter is held off
        apb_write(ADDR_LCR, lcr_word(5'h03), err);
        apb_write(ADDR_OCR, 32'h2, err);
        for (int i = 0; i < 5; i++) begin
            rng = xorshift32(rng);
            if (i < 4) begin
                sb_q.push_back(rng[7:0]);
            end
            apb_write(ADDR_TDR, {24'b0, rng[7:0]}, err);
            check_value("pslverr_o", err, i == 4);
        end
        apb_write(ADDR_OCR, 32'h3, err);
        for (int i = 0; i < 4; i++) begin
            wait_lsr(8'h02, seen);
            check_rdr();
        end

        // parity error from the serial driver
        @(posedge clk);
        loopback <= 1'b0;
        apb_write(ADDR_LCR, lcr_word(5'h0B), err);
        apb_write(ADDR_IER, 32'h4, err);
        apb_write(ADDR_OCR, 32'h2, err);
        rng = xorshift32(rng);
        b1 = rng[7:0];
        sb_q.push_back(b1);
        send_serial(b1, 5'h0B, 1'b1);
        wait_irq();
        apb_read(ADDR_IIR, data, err);
        check_value("IIR", data, 32'h6);
        apb_read(ADDR_LSR, data, err);
        check_value("LSR.PARITY_ERR", data[LSR_PARITY_ERR], 1);
        apb_read(ADDR_LSR, data, err);
        check_value("LSR.PARITY_ERR", data[LSR_PARITY_ERR], 0);
        repeat (2) @(negedge clk);
        check_value("irq_o", irq, 0);
        check_rdr();
        apb_write(ADDR_IER, 32'h0, err);

        // overrun, second frame overwrites RDR
        apb_write(ADDR_LCR, lcr_word(5'h03), err);
        rng = xorshift32(rng);
        b1 = rng[7:0];
        rng = xorshift32(rng);
        b2 = rng[7:0];
        sb_q.push_back(b2);
        send_serial(b1, 5'h03, 1'b0);
        send_serial(b2, 5'h03, 1'b0);
        wait_lsr(8'h40, seen);
        check_value("LSR.OVERRUN", seen[LSR_OVERRUN], 1);
        check_value("LSR.DATA_READY", seen[LSR_DATA_READY], 1);
        check_rdr();

        repeat (4) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: hw/apb_uart.sv
// single clock domain; rx_i may be asynchronous and is synchronized in the receiver
`default_nettype none

module apb_uart import uart_reg_pkg::*; #(
    parameter int unsigned SYS_FREQ      = 125_000_000,
    parameter int unsigned OVERSAMPLE    = 16,
    parameter int unsigned TX_FIFO_DEPTH = 4
) (
    input  wire        clk,
    input  wire        preset_n,
    input  wire        psel_i,
    input  wire        penable_i,
    input  wire        pwrite_i,
    input  wire [11:0] paddr_i,
    input  wire [31:0] pwdata_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    output logic       irq_o,
    input  wire        rx_i,
    output logic       tx_o
);
    uart_core_if core ();

    apb_uart_regs i_regs (
        .clk       (clk),
        .preset_n  (preset_n),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .irq_o     (irq_o),
        .core      (core)
    );

    uart_baud_gen #(
        .SYS_FREQ   (SYS_FREQ),
        .OVERSAMPLE (OVERSAMPLE)
    ) i_baud_gen (
        .clk      (clk),
        .preset_n (preset_n),
        .core     (core)
    );

    uart_tx #(.TX_FIFO_DEPTH(TX_FIFO_DEPTH)) i_tx (
        .clk      (clk),
        .preset_n (preset_n),
        .core     (core),
        .tx_o     (tx_o)
    );

    uart_rx #(.OVERSAMPLE(OVERSAMPLE)) i_rx (
        .clk      (clk),
        .preset_n (preset_n),
        .core     (core),
        .rx_i     (rx_i)
    );
endmodule

`default_nettype wire

// File: hw/uart_rx.sv
// one sample per bit at mid-bit, no majority vote; a second stop bit is taken as line idle
`default_nettype none

module uart_rx import uart_frame_pkg::*; #(
    parameter int unsigned OVERSAMPLE = 16
) (
    input  wire     clk,
    input  wire     preset_n,
    uart_core_if.rx core,
    input  wire     rx_i
);
    localparam int OS_W = $clog2(OVERSAMPLE);

    // two sync flops plus the previous synchronized level
    logic [2:0]      rx_sync;
    logic            rx_s, start_edge, half_bit, mid_bit;
    rx_state_t       state;
    logic [OS_W-1:0] tick_cnt;
    logic [2:0]      bit_cnt;
    uart_byte_t      shreg;
    logic            par_err;

    assign rx_s = rx_sync[1];
    assign start_edge = rx_sync[2] && !rx_s;
    assign half_bit = core.sample_tick && (tick_cnt == OS_W'(OVERSAMPLE / 2 - 1));
    assign mid_bit = core.sample_tick && (tick_cnt == OS_W'(OVERSAMPLE - 1));

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            rx_sync <= '1;
            state <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt <= '0;
            core.rx_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], rx_i};
            core.rx_valid <= 1'b0;
            if (core.sample_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            if (!core.rx_en) begin
                state <= RX_IDLE;
            end else begin
                case (state)
                    RX_IDLE: if (start_edge) begin
                        state <= RX_START;
                        tick_cnt <= '0;
                    end
                    // a start bit gone high by half a bit was a glitch
                    RX_START: if (half_bit) begin
                        state <= rx_s ? RX_IDLE : RX_DATA;
                        tick_cnt <= '0;
                        bit_cnt <= '0;
                    end
                    RX_DATA: if (mid_bit) begin
                        tick_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == {1'b1, core.data_bits}) begin
                            state <= core.parity_en ? RX_PARITY : RX_STOP;
                        end
                    end
                    RX_PARITY: if (mid_bit) begin
                        tick_cnt <= '0;
                        state <= RX_STOP;
                    end
                    default: if (mid_bit) begin
                        state <= RX_IDLE;
                        core.rx_valid <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_START) begin
            shreg <= '0;
            par_err <= 1'b0;
        end
        if (mid_bit) begin
            case (state)
                RX_DATA: shreg[bit_cnt] <= rx_s;
                RX_PARITY: par_err <= rx_s ^ (^shreg) ^ core.parity_odd;
                RX_STOP: begin
                    core.rx_data <= shreg;
                    core.rx_parity_err <= par_err;
                    core.rx_stop_err <= !rx_s;
                end
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!preset_n) core.rx_valid |=> !core.rx_valid);
endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// TX_FIFO_DEPTH must be a power of two; LCR is used live, so change it only while idle
`default_nettype none

module uart_tx import uart_frame_pkg::*; #(
    parameter int unsigned TX_FIFO_DEPTH = 4
) (
    input  wire     clk,
    input  wire     preset_n,
    uart_core_if.tx core,
    output logic    tx_o
);
    localparam int PTR_W = $clog2(TX_FIFO_DEPTH);

    uart_byte_t       fifo_mem [TX_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;
    uart_byte_t       head;
    tx_state_t        state;
    uart_byte_t       shreg;
    logic [2:0]       bit_cnt;
    logic             stop_cnt;
    logic             par_bit;
    logic             tx_bit;

    assign core.tx_empty = (count == '0);
    assign core.tx_full = (count == (PTR_W + 1)'(TX_FIFO_DEPTH));
    assign pop = (state == TX_IDLE) && core.bit_tick && core.tx_en && !core.tx_empty;
    assign core.tx_done = (state == TX_STOP) && core.bit_tick && (stop_cnt || !core.two_stop);
    // upper bits masked so parity covers the frame's data only
    assign head = fifo_mem[rd_ptr] & (8'hff >> (2'd3 - core.data_bits));

    always_ff @(posedge clk) begin
        if (core.tx_push) begin
            fifo_mem[wr_ptr] <= core.tx_data;
        end
        if (pop) begin
            shreg <= head;
            par_bit <= ^head ^ core.parity_odd;
        end else if (core.bit_tick && state == TX_DATA) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(core.tx_push);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count <= count + (PTR_W + 1)'(core.tx_push) - (PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            state <= TX_IDLE;
            bit_cnt <= '0;
            stop_cnt <= 1'b0;
        end else if (core.bit_tick) begin
            case (state)
                TX_IDLE: state <= pop ? TX_START : TX_IDLE;
                TX_START: begin
                    state <= TX_DATA;
                    bit_cnt <= '0;
                    stop_cnt <= 1'b0;
                end
                TX_DATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    // last index is 4 + data_bits
                    if (bit_cnt == {1'b1, core.data_bits}) begin
                        state <= core.parity_en ? TX_PARITY : TX_STOP;
                    end
                end
                TX_PARITY: state <= TX_STOP;
                default: begin
                    stop_cnt <= 1'b1;
                    state <= core.tx_done ? TX_IDLE : TX_STOP;
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            TX_START: tx_bit = 1'b0;
            TX_DATA: tx_bit = shreg[0];
            TX_PARITY: tx_bit = par_bit;
            default: tx_bit = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            tx_o <= 1'b1;
        end else begin
            tx_o <= tx_bit;
        end
    end

    // register block must hold back pushes into a full FIFO
    assert property (@(posedge clk) disable iff (!preset_n) core.tx_push |-> !core.tx_full);
endmodule

`default_nettype wire

// File: hw/uart_baud_gen.sv
// SYS_FREQ must be at least 921600*OVERSAMPLE; integer division leaves some rate error
`default_nettype none

module uart_baud_gen import uart_frame_pkg::*; #(
    parameter int unsigned SYS_FREQ   = 125_000_000,
    parameter int unsigned OVERSAMPLE = 16
) (
    input  wire       clk,
    input  wire       preset_n,
    uart_core_if.baud core
);
    localparam int DIV_W = $clog2(SYS_FREQ / (BAUD_TABLE[0] * OVERSAMPLE) + 1);
    localparam int OS_W = $clog2(OVERSAMPLE);

    logic [DIV_W-1:0] div_rom [8];
    logic [DIV_W-1:0] div_cnt;
    logic [OS_W-1:0]  os_cnt;
    baud_sel_t        sel_q;
    logic             restart;

    // reload values fixed at elaboration
    for (genvar i = 0; i < 8; i++) begin : g_rom
        assign div_rom[i] = DIV_W'(SYS_FREQ / (BAUD_TABLE[i] * OVERSAMPLE) - 1);
    end

    assign restart = (core.baud_sel != sel_q);
    assign core.sample_tick = !restart && (div_cnt == div_rom[core.baud_sel]);
    assign core.bit_tick = core.sample_tick && (os_cnt == OS_W'(OVERSAMPLE - 1));

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            sel_q <= '0;
            div_cnt <= '0;
            os_cnt <= '0;
        end else begin
            sel_q <= core.baud_sel;
            if (restart || core.sample_tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (restart || core.bit_tick) begin
                os_cnt <= '0;
            end else if (core.sample_tick) begin
                os_cnt <= os_cnt + 1'b1;
            end
        end
    end

    // bit ticks are OVERSAMPLE sample ticks apart, never back to back
    assert property (@(posedge clk) disable iff (!preset_n)
        core.bit_tick |=> !core.bit_tick);
endmodule

`default_nettype wire

// File: hw/apb_uart_regs.sv
// no pstrb and no wait states; a TDR write while the transmit FIFO is full is dropped with an error
`default_nettype none

module apb_uart_regs import uart_reg_pkg::*, uart_frame_pkg::*; (
    input  wire       clk,
    input  wire       preset_n,
    input  wire       psel_i,
    input  wire       penable_i,
    input  wire       pwrite_i,
    input  wire [11:0] paddr_i,
    input  wire [31:0] pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    output logic      irq_o,
    uart_core_if.regs core
);
    logic             access, wr, rd, mapped, wr_ro;
    logic             rd_rdr, rd_lsr, rd_iir;
    logic [LCR_W-1:0] lcr_q;
    logic [OCR_W-1:0] ocr_q;
    logic [IER_W-1:0] ier_q;
    uart_byte_t       rdr_q;
    logic             tx_done_q, data_ready_q, parity_err_q, stop_err_q, overrun_q;
    apb_data_t        lsr_val;
    iir_code_t        iir_q, iir_next;

    assign access = psel_i && penable_i;
    assign wr = access && pwrite_i;
    assign rd = access && !pwrite_i;
    assign pready_o = 1'b1;
    assign mapped = paddr_i inside {ADDR_TDR, ADDR_RDR, ADDR_LCR, ADDR_OCR, ADDR_LSR,
                                    ADDR_IER, ADDR_IIR};
    assign wr_ro = paddr_i inside {ADDR_RDR, ADDR_LSR, ADDR_IIR};
    assign pslverr_o = access && (!mapped || (pwrite_i && wr_ro)
                       || (pwrite_i && paddr_i == ADDR_TDR && core.tx_full));
    assign rd_rdr = rd && paddr_i == ADDR_RDR;
    assign rd_lsr = rd && paddr_i == ADDR_LSR;
    assign rd_iir = rd && paddr_i == ADDR_IIR;

    assign core.tx_push = wr && paddr_i == ADDR_TDR && !core.tx_full;
    assign core.tx_data = pwdata_i[7:0];
    assign core.data_bits = lcr_q[LCR_DBITS +: 2];
    assign core.two_stop = lcr_q[LCR_STOP2];
    assign core.parity_en = lcr_q[LCR_PEN];
    assign core.parity_odd = lcr_q[LCR_PODD];
    assign core.baud_sel = lcr_q[LCR_BAUD +: 3];
    assign core.tx_en = ocr_q[OCR_TXEN];
    assign core.rx_en = ocr_q[OCR_RXEN];
    assign irq_o = (iir_q != IIR_NONE);

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            lcr_q <= '0;
            ocr_q <= '0;
            ier_q <= '0;
        end else if (wr) begin
            case (paddr_i)
                ADDR_LCR: lcr_q <= pwdata_i[LCR_W-1:0];
                ADDR_OCR: ocr_q <= pwdata_i[OCR_W-1:0];
                ADDR_IER: ier_q <= pwdata_i[IER_W-1:0];
                default: ;
            endcase
        end
    end

    // status bits, set wins over a clearing read
    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            rdr_q <= '0;
            tx_done_q <= 1'b0;
            data_ready_q <= 1'b0;
            parity_err_q <= 1'b0;
            stop_err_q <= 1'b0;
            overrun_q <= 1'b0;
            iir_q <= IIR_NONE;
        end else begin
            if (core.rx_valid) begin
                rdr_q <= core.rx_data;
            end
            tx_done_q <= core.tx_done || (tx_done_q && !rd_lsr);
            data_ready_q <= core.rx_valid || (data_ready_q && !rd_rdr);
            parity_err_q <= (core.rx_valid && core.rx_parity_err) || (parity_err_q && !rd_lsr);
            stop_err_q <= (core.rx_valid && core.rx_stop_err) || (stop_err_q && !rd_lsr);
            overrun_q <= (core.rx_valid && data_ready_q) || (overrun_q && !rd_lsr);
            iir_q <= rd_iir ? IIR_NONE : iir_next;
        end
    end

    // line status first, then receive, then transmitter empty
    always_comb begin
        if (ier_q[IER_LINE] && (parity_err_q || stop_err_q || overrun_q)) begin
            iir_next = IIR_LINE;
        end else if (ier_q[IER_RX] && data_ready_q) begin
            iir_next = IIR_RX;
        end else if (ier_q[IER_TX] && core.tx_empty) begin
            iir_next = IIR_TX;
        end else begin
            iir_next = IIR_NONE;
        end
    end

    always_comb begin
        lsr_val = '0;
        lsr_val[LSR_TX_DONE] = tx_done_q;
        lsr_val[LSR_DATA_READY] = data_ready_q;
        lsr_val[LSR_PARITY_ERR] = parity_err_q;
        lsr_val[LSR_STOP_ERR] = stop_err_q;
        lsr_val[LSR_TX_EMPTY] = core.tx_empty;
        lsr_val[LSR_OVERRUN] = overrun_q;
        prdata_o = '0;
        if (rd) begin
            case (paddr_i)
                ADDR_RDR: prdata_o = apb_data_t'(rdr_q);
                ADDR_LCR: prdata_o = apb_data_t'(lcr_q);
                ADDR_OCR: prdata_o = apb_data_t'(ocr_q);
                ADDR_LSR: prdata_o = lsr_val;
                ADDR_IER: prdata_o = apb_data_t'(ier_q);
                ADDR_IIR: prdata_o = apb_data_t'(iir_q);
                default: ;
            endcase
        end
    end

    // an access answered with an error leaves the configuration untouched
    assert property (@(posedge clk) disable iff (!preset_n)
        pslverr_o |=> $stable(lcr_q) && $stable(ocr_q) && $stable(ier_q));
    assert property (@(posedge clk) disable iff (!preset_n)
        iir_q inside {IIR_NONE, IIR_LINE, IIR_RX, IIR_TX});
endmodule

`default_nettype wire

// File: hw/uart_core_if.sv
// single clock domain; all strobes here are one clk cycle wide
`default_nettype none

interface uart_core_if import uart_frame_pkg::*; ();
    // configuration from the register block
    data_bits_t data_bits;
    baud_sel_t  baud_sel;
    uart_byte_t tx_data;
    logic       two_stop, parity_en, parity_odd;
    logic       tx_en, rx_en, tx_push;
    // engine outputs
    logic       sample_tick, bit_tick;
    logic       tx_full, tx_empty, tx_done;
    uart_byte_t rx_data;
    logic       rx_valid, rx_parity_err, rx_stop_err;

    modport regs (
        output data_bits, two_stop, parity_en, parity_odd, baud_sel, tx_en, rx_en,
        output tx_push, tx_data,
        input  tx_full, tx_empty, tx_done, rx_data, rx_valid, rx_parity_err, rx_stop_err
    );
    modport baud (input baud_sel, output sample_tick, bit_tick);
    modport tx (
        input  data_bits, two_stop, parity_en, parity_odd, tx_en, tx_push, tx_data, bit_tick,
        output tx_full, tx_empty, tx_done
    );
    modport rx (
        input  data_bits, parity_en, parity_odd, rx_en, sample_tick,
        output rx_data, rx_valid, rx_parity_err, rx_stop_err
    );
endinterface

`default_nettype wire

// File: hw/uart_frame_pkg.sv
// line format and serial engine types; baud table entries are in bits per second
`default_nettype none

package uart_frame_pkg;
    typedef logic [7:0] uart_byte_t;
    // value n selects 5+n data bits
    typedef logic [1:0] data_bits_t;
    typedef logic [2:0] baud_sel_t;

    localparam int unsigned BAUD_TABLE [8] = '{
        9600, 19200, 38400, 57600, 115200, 230400, 460800, 921600
    };

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_t;
endpackage

`default_nettype wire

// File: hw/uart_reg_pkg.sv
// 32-bit zero-wait APB3 register map; only the low byte of each register carries data
`default_nettype none

package uart_reg_pkg;
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t ADDR_TDR = 12'h000;
    localparam apb_addr_t ADDR_RDR = 12'h004;
    localparam apb_addr_t ADDR_LCR = 12'h008;
    localparam apb_addr_t ADDR_OCR = 12'h00C;
    localparam apb_addr_t ADDR_LSR = 12'h010;
    localparam apb_addr_t ADDR_IER = 12'h014;
    localparam apb_addr_t ADDR_IIR = 12'h018;

    // field widths and bit positions
    localparam int LCR_W = 8;
    localparam int OCR_W = 2;
    localparam int IER_W = 3;
    localparam int LCR_DBITS = 0;
    localparam int LCR_STOP2 = 2;
    localparam int LCR_PEN = 3;
    localparam int LCR_PODD = 4;
    localparam int LCR_BAUD = 5;
    localparam int OCR_TXEN = 0;
    localparam int OCR_RXEN = 1;
    localparam int LSR_TX_DONE = 0;
    localparam int LSR_DATA_READY = 1;
    localparam int LSR_PARITY_ERR = 2;
    localparam int LSR_STOP_ERR = 3;
    localparam int LSR_TX_EMPTY = 4;
    localparam int LSR_OVERRUN = 6;
    localparam int IER_RX = 0;
    localparam int IER_TX = 1;
    localparam int IER_LINE = 2;

    typedef enum logic [2:0] {
        IIR_NONE = 3'b001,
        IIR_LINE = 3'b110,
        IIR_RX   = 3'b100,
        IIR_TX   = 3'b010
    } iir_code_t;
endpackage

`default_nettype wire
